/* common/dlx_cfg.svh */
`ifndef DLX_CFG_SVH
`define DLX_CFG_SVH

// data path and address width in bits
`define DLX_XLEN 32

// architectural registers, r0 included
`define DLX_NREGS 32

// instruction memory depth in words
`define DLX_IMEM_DEPTH 256

// data memory depth in words
`define DLX_DMEM_DEPTH 256

`endif

/* common/dlx_isa_pkg.sv */
`default_nettype none

`include "dlx_cfg.svh"

package dlx_isa_pkg;

   // machine word and register index
   typedef logic [`DLX_XLEN-1:0] word_t;
   typedef logic [$clog2(`DLX_NREGS)-1:0] reg_idx_t;

   // primary opcodes
   // r-type is 0 and selects on funct
   typedef enum logic [5:0] {
      op_rtype = 6'h00,
      op_j     = 6'h02,
      op_beqz  = 6'h04,
      op_bnez  = 6'h05,
      op_addi  = 6'h08,
      op_andi  = 6'h0c,
      op_ori   = 6'h0d,
      op_xori  = 6'h0e,
      op_slti  = 6'h1a,
      op_lw    = 6'h23,
      op_sw    = 6'h2b
   } opcode_t;

   // r-type function codes
   typedef enum logic [5:0] {
      fn_sll = 6'h04,
      fn_srl = 6'h06,
      fn_add = 6'h20,
      fn_sub = 6'h22,
      fn_and = 6'h24,
      fn_or  = 6'h25,
      fn_xor = 6'h26,
      fn_slt = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_sll,
      alu_srl,
      alu_slt
   } alu_op_t;

   // fields in dlx order, msb first
   // i-type immediate is the low 16 bits, j offset the low 26
   typedef struct packed {
      opcode_t     opcode;
      reg_idx_t    rs1;
      reg_idx_t    rs2;
      reg_idx_t    rd;
      logic [4:0]  shamt;
      funct_t      funct;
   } instr_t;

endpackage

`default_nettype wire

/* common/dlx_pipe_pkg.sv */
`default_nettype none

package dlx_pipe_pkg;

   // fetch to decode
   typedef struct packed {
      logic                  valid;
      dlx_isa_pkg::word_t    pc_plus4;
      dlx_isa_pkg::instr_t   instr;
   } if_id_t;

   // decode to execute
   // operand values are raw register file reads, execute forwards over them
   typedef struct packed {
      logic                  valid;
      dlx_isa_pkg::word_t    pc_plus4;
      dlx_isa_pkg::word_t    rs1_val;
      dlx_isa_pkg::word_t    rs2_val;
      dlx_isa_pkg::reg_idx_t rs1_idx;
      dlx_isa_pkg::reg_idx_t rs2_idx;
      dlx_isa_pkg::reg_idx_t dst;
      logic [15:0]           imm16;
      logic                  sign_ext;
      logic                  use_imm;
      dlx_isa_pkg::alu_op_t  alu_op;
      logic                  reg_write;
      logic                  mem_write;
      logic                  mem_to_reg;
   } id_ex_t;

   // execute to memory
   typedef struct packed {
      logic                  valid;
      dlx_isa_pkg::word_t    alu_result;
      dlx_isa_pkg::word_t    store_data;
      dlx_isa_pkg::reg_idx_t dst;
      logic                  reg_write;
      logic                  mem_write;
      logic                  mem_to_reg;
   } ex_mem_t;

   // memory to writeback
   typedef struct packed {
      logic                  valid;
      dlx_isa_pkg::reg_idx_t dst;
      dlx_isa_pkg::word_t    wb_data;
      logic                  reg_write;
   } mem_wb_t;

endpackage

`default_nettype wire

/* common/dlx_fwd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dlx_fwd_if;

   // register result still in flight in one stage
   logic                  reg_write;
   dlx_isa_pkg::reg_idx_t dst;
   dlx_isa_pkg::word_t    data;
   // data not ready yet, load still in execute
   logic                  is_load;

   modport producer (output reg_write, dst, data, is_load);
   modport consumer (input reg_write, dst, data, is_load);

endinterface

`default_nettype wire

/* source/dlx_pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module dlx_pipe_reg #(
   parameter type T = logic
) (
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic stall,
   input  wire logic flush,
   input  wire T     bubble,
   input  wire T     d,
   output T          q
);

   // flush beats stall, stall beats load
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         q <= bubble;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

/* source/dlx_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_fetch (
   input  wire logic                                clk,
   input  wire logic                                rst,
   input  wire logic                                stall,
   input  wire logic                                redirect,
   input  wire dlx_isa_pkg::word_t                  target,
   input  wire logic                                load_en,
   input  wire logic [$clog2(`DLX_IMEM_DEPTH)-1:0]  load_addr,
   input  wire dlx_isa_pkg::word_t                  load_data,
   output dlx_pipe_pkg::if_id_t                     if_out,
   output dlx_isa_pkg::word_t                       pc
);

   localparam int IMEM_AW = $clog2(`DLX_IMEM_DEPTH);

   dlx_isa_pkg::word_t imem [`DLX_IMEM_DEPTH];

   // program load port, normally used while rst is high
   always_ff @(posedge clk) begin
      if (load_en) begin
         imem[load_addr] <= load_data;
      end
   end

   // redirect from decode wins over the sequential pc
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= target;
      end else if (!stall) begin
         pc <= pc + 'd4;
      end
   end

   // word-addressed read of the current pc
   // the fetched word is valid once out of reset
   assign if_out.valid    = !rst;
   assign if_out.pc_plus4 = pc + 'd4;
   assign if_out.instr    = dlx_isa_pkg::instr_t'(imem[pc[IMEM_AW+1:2]]);

   // decode only resolves a branch once it is no longer stalled
   a_redirect_no_stall: assert property (
      @(posedge clk) disable iff (rst) redirect |-> !stall
   );

endmodule

`default_nettype wire

/* decode/dlx_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_regfile (
   input  wire logic                  clk,
   input  wire dlx_isa_pkg::reg_idx_t rs1_idx,
   input  wire dlx_isa_pkg::reg_idx_t rs2_idx,
   input  wire logic                  we,
   input  wire dlx_isa_pkg::reg_idx_t wr_idx,
   input  wire dlx_isa_pkg::word_t    wr_data,
   output dlx_isa_pkg::word_t         rs1_val,
   output dlx_isa_pkg::word_t         rs2_val
);

   dlx_isa_pkg::word_t regs [`DLX_NREGS];

   always_ff @(posedge clk) begin
      if (we && wr_idx != '0) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // r0 reads zero
   // a same-cycle write shows up on the read side, covering writeback to decode
   assign rs1_val = (rs1_idx == '0) ? '0 :
                    (we && wr_idx == rs1_idx) ? wr_data : regs[rs1_idx];
   assign rs2_val = (rs2_idx == '0) ? '0 :
                    (we && wr_idx == rs2_idx) ? wr_data : regs[rs2_idx];

   // decode already drops reg_write for r0 destinations
   a_no_r0_write: assert property (@(posedge clk) we |-> wr_idx != '0);

endmodule

`default_nettype wire

/* decode/dlx_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_decode (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire dlx_pipe_pkg::if_id_t  id_in,
   dlx_fwd_if.consumer                fwd_ex,
   dlx_fwd_if.consumer                fwd_mem,
   input  wire logic                  wb_en,
   input  wire dlx_isa_pkg::reg_idx_t wb_reg,
   input  wire dlx_isa_pkg::word_t    wb_data,
   output dlx_pipe_pkg::id_ex_t       id_out,
   output logic                       stall,
   output logic                       redirect,
   output dlx_isa_pkg::word_t         target
);

   dlx_isa_pkg::instr_t   instr;
   dlx_isa_pkg::word_t    rf_rs1;
   dlx_isa_pkg::word_t    rf_rs2;
   dlx_isa_pkg::word_t    rs1_fwd;
   dlx_isa_pkg::reg_idx_t dst;
   dlx_isa_pkg::alu_op_t  alu_op;
   logic                  is_rtype;
   logic                  is_imm_alu;
   logic                  is_zext;
   logic                  is_lw;
   logic                  is_sw;
   logic                  is_br;
   logic                  is_j;
   logic                  funct_ok;
   logic                  taken;
   logic                  uses_rs1;
   logic                  uses_rs2;

   assign instr = id_in.instr;

   dlx_regfile regfile_inst (
      .clk     (clk),
      .rs1_idx (instr.rs1),
      .rs2_idx (instr.rs2),
      .we      (wb_en),
      .wr_idx  (wb_reg),
      .wr_data (wb_data),
      .rs1_val (rf_rs1),
      .rs2_val (rf_rs2)
   );

   // instruction class
   assign is_rtype   = instr.opcode == dlx_isa_pkg::op_rtype;
   assign is_zext    = instr.opcode inside {dlx_isa_pkg::op_andi, dlx_isa_pkg::op_ori,
                                            dlx_isa_pkg::op_xori};
   assign is_imm_alu = is_zext ||
                       instr.opcode inside {dlx_isa_pkg::op_addi, dlx_isa_pkg::op_slti};
   assign is_lw      = instr.opcode == dlx_isa_pkg::op_lw;
   assign is_sw      = instr.opcode == dlx_isa_pkg::op_sw;
   assign is_br      = instr.opcode inside {dlx_isa_pkg::op_beqz, dlx_isa_pkg::op_bnez};
   assign is_j       = instr.opcode == dlx_isa_pkg::op_j;

   // alu operation from funct or from opcode
   // loads and stores add the offset to the base
   always_comb begin
      alu_op   = dlx_isa_pkg::alu_add;
      funct_ok = 1'b1;
      if (is_rtype) begin
         case (instr.funct)
            dlx_isa_pkg::fn_add: alu_op = dlx_isa_pkg::alu_add;
            dlx_isa_pkg::fn_sub: alu_op = dlx_isa_pkg::alu_sub;
            dlx_isa_pkg::fn_and: alu_op = dlx_isa_pkg::alu_and;
            dlx_isa_pkg::fn_or:  alu_op = dlx_isa_pkg::alu_or;
            dlx_isa_pkg::fn_xor: alu_op = dlx_isa_pkg::alu_xor;
            dlx_isa_pkg::fn_sll: alu_op = dlx_isa_pkg::alu_sll;
            dlx_isa_pkg::fn_srl: alu_op = dlx_isa_pkg::alu_srl;
            dlx_isa_pkg::fn_slt: alu_op = dlx_isa_pkg::alu_slt;
            default:             funct_ok = 1'b0;
         endcase
      end else begin
         case (instr.opcode)
            dlx_isa_pkg::op_andi: alu_op = dlx_isa_pkg::alu_and;
            dlx_isa_pkg::op_ori:  alu_op = dlx_isa_pkg::alu_or;
            dlx_isa_pkg::op_xori: alu_op = dlx_isa_pkg::alu_xor;
            dlx_isa_pkg::op_slti: alu_op = dlx_isa_pkg::alu_slt;
            default:              alu_op = dlx_isa_pkg::alu_add;
         endcase
      end
   end

   // r-type writes rd, i-type writes the rs2 field
   assign dst      = is_rtype ? instr.rd : instr.rs2;
   assign uses_rs1 = !is_j;
   assign uses_rs2 = is_rtype || is_sw;

   always_comb begin
      id_out.valid      = id_in.valid;
      id_out.pc_plus4   = id_in.pc_plus4;
      id_out.rs1_val    = rf_rs1;
      id_out.rs2_val    = rf_rs2;
      id_out.rs1_idx    = instr.rs1;
      id_out.rs2_idx    = instr.rs2;
      id_out.dst        = dst;
      id_out.imm16      = instr[15:0];
      id_out.sign_ext   = !is_zext;
      id_out.use_imm    = !is_rtype;
      id_out.alu_op     = alu_op;
      // nothing lands in r0
      id_out.reg_write  = ((is_rtype && funct_ok) || is_imm_alu || is_lw) && dst != '0;
      id_out.mem_write  = is_sw;
      id_out.mem_to_reg = is_lw;
   end

   // branch operand, newest producer first
   // a load in execute never gets here since it stalls first
   always_comb begin
      if (fwd_ex.reg_write && fwd_ex.dst == instr.rs1)
         rs1_fwd = fwd_ex.data;
      else if (fwd_mem.reg_write && fwd_mem.dst == instr.rs1)
         rs1_fwd = fwd_mem.data;
      else
         rs1_fwd = rf_rs1;
   end

   // load-use hazard
   // one cycle is enough for the load to reach memory
   assign stall = id_in.valid && fwd_ex.reg_write && fwd_ex.is_load &&
                  ((uses_rs1 && fwd_ex.dst == instr.rs1) ||
                   (uses_rs2 && fwd_ex.dst == instr.rs2));

   always_comb begin
      case (instr.opcode)
         dlx_isa_pkg::op_beqz: taken = rs1_fwd == '0;
         dlx_isa_pkg::op_bnez: taken = rs1_fwd != '0;
         default:              taken = is_j;
      endcase
   end

   // offsets are relative to pc_plus4, no delay slot
   assign target = is_br ?
      id_in.pc_plus4 + {{(`DLX_XLEN-16){instr[15]}}, instr[15:0]} :
      id_in.pc_plus4 + {{(`DLX_XLEN-26){instr[25]}}, instr[25:0]};
   assign redirect = id_in.valid && !stall && taken;

   // a stall always clears after one cycle
   a_stall_one_cycle: assert property (
      @(posedge clk) disable iff (rst) stall |=> !stall
   );

endmodule

`default_nettype wire

/* execute/dlx_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module dlx_alu (
   input  wire dlx_isa_pkg::alu_op_t op,
   input  wire dlx_isa_pkg::word_t   a,
   input  wire dlx_isa_pkg::word_t   b,
   output dlx_isa_pkg::word_t        y
);

   logic [4:0] shamt;

   // shift amount is the low five bits of b
   assign shamt = b[4:0];

   always_comb begin
      case (op)
         dlx_isa_pkg::alu_add: y = a + b;
         dlx_isa_pkg::alu_sub: y = a - b;
         dlx_isa_pkg::alu_and: y = a & b;
         dlx_isa_pkg::alu_or:  y = a | b;
         dlx_isa_pkg::alu_xor: y = a ^ b;
         dlx_isa_pkg::alu_sll: y = a << shamt;
         // logical shift, zero fill
         dlx_isa_pkg::alu_srl: y = a >> shamt;
         // signed compare, result is 0 or 1
         dlx_isa_pkg::alu_slt: y = ($signed(a) < $signed(b)) ? 'd1 : '0;
         default:              y = '0;
      endcase
   end

endmodule

`default_nettype wire

/* execute/dlx_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_execute (
   input  wire dlx_pipe_pkg::id_ex_t ex_in,
   dlx_fwd_if.consumer               fwd_mem,
   dlx_fwd_if.consumer               fwd_wb,
   dlx_fwd_if.producer               fwd_ex,
   output dlx_pipe_pkg::ex_mem_t     ex_out
);

   dlx_isa_pkg::word_t rs1_fwd;
   dlx_isa_pkg::word_t rs2_fwd;
   dlx_isa_pkg::word_t imm;
   dlx_isa_pkg::word_t alu_b;
   dlx_isa_pkg::word_t alu_y;

   // memory stage is newer than writeback, so it goes first
   always_comb begin
      if (fwd_mem.reg_write && fwd_mem.dst == ex_in.rs1_idx)
         rs1_fwd = fwd_mem.data;
      else if (fwd_wb.reg_write && fwd_wb.dst == ex_in.rs1_idx)
         rs1_fwd = fwd_wb.data;
      else
         rs1_fwd = ex_in.rs1_val;

      if (fwd_mem.reg_write && fwd_mem.dst == ex_in.rs2_idx)
         rs2_fwd = fwd_mem.data;
      else if (fwd_wb.reg_write && fwd_wb.dst == ex_in.rs2_idx)
         rs2_fwd = fwd_wb.data;
      else
         rs2_fwd = ex_in.rs2_val;
   end

   // andi, ori, xori zero-extend
   assign imm   = ex_in.sign_ext ? {{(`DLX_XLEN-16){ex_in.imm16[15]}}, ex_in.imm16} :
                                   {{(`DLX_XLEN-16){1'b0}}, ex_in.imm16};
   assign alu_b = ex_in.use_imm ? imm : rs2_fwd;

   dlx_alu alu_inst (
      .op (ex_in.alu_op),
      .a  (rs1_fwd),
      .b  (alu_b),
      .y  (alu_y)
   );

   // result offered to decode
   // for a load this is only the address
   assign fwd_ex.reg_write = ex_in.valid && ex_in.reg_write;
   assign fwd_ex.dst       = ex_in.dst;
   assign fwd_ex.data      = alu_y;
   assign fwd_ex.is_load   = ex_in.mem_to_reg;

   // sw stores the forwarded rs2
   assign ex_out.valid      = ex_in.valid;
   assign ex_out.alu_result = alu_y;
   assign ex_out.store_data = rs2_fwd;
   assign ex_out.dst        = ex_in.dst;
   assign ex_out.reg_write  = ex_in.reg_write;
   assign ex_out.mem_write  = ex_in.mem_write;
   assign ex_out.mem_to_reg = ex_in.mem_to_reg;

endmodule

`default_nettype wire

/* source/dlx_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_mem_stage (
   input  wire logic                 clk,
   input  wire dlx_pipe_pkg::ex_mem_t mem_in,
   dlx_fwd_if.producer               fwd_mem,
   output dlx_pipe_pkg::mem_wb_t     mem_out,
   output logic                      st_en,
   output dlx_isa_pkg::word_t        st_addr,
   output dlx_isa_pkg::word_t        st_data
);

   localparam int DMEM_AW = $clog2(`DLX_DMEM_DEPTH);

   dlx_isa_pkg::word_t                    dmem [`DLX_DMEM_DEPTH];
   logic               [DMEM_AW-1:0]      word_idx;
   dlx_isa_pkg::word_t                    wb_data;

   // word address, byte offset ignored
   assign word_idx = mem_in.alu_result[DMEM_AW+1:2];

   // store ports mirror the write of this cycle
   assign st_en   = mem_in.valid && mem_in.mem_write;
   assign st_addr = mem_in.alu_result;
   assign st_data = mem_in.store_data;

   always_ff @(posedge clk) begin
      if (st_en) begin
         dmem[word_idx] <= mem_in.store_data;
      end
   end

   // combinational read, so loads forward from here
   assign wb_data = mem_in.mem_to_reg ? dmem[word_idx] : mem_in.alu_result;

   assign fwd_mem.reg_write = mem_in.valid && mem_in.reg_write;
   assign fwd_mem.dst       = mem_in.dst;
   assign fwd_mem.data      = wb_data;
   assign fwd_mem.is_load   = mem_in.mem_to_reg;

   assign mem_out.valid     = mem_in.valid;
   assign mem_out.dst       = mem_in.dst;
   assign mem_out.wb_data   = wb_data;
   assign mem_out.reg_write = mem_in.reg_write;

endmodule

`default_nettype wire

/* source/dlx_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_cpu (
   input  wire logic                                clk,
   input  wire logic                                rst,
   input  wire logic                                load_en,
   input  wire logic [$clog2(`DLX_IMEM_DEPTH)-1:0]  load_addr,
   input  wire dlx_isa_pkg::word_t                  load_data,
   output logic                                     wb_en,
   output dlx_isa_pkg::reg_idx_t                    wb_reg,
   output dlx_isa_pkg::word_t                       wb_data,
   output logic                                     st_en,
   output dlx_isa_pkg::word_t                       st_addr,
   output dlx_isa_pkg::word_t                       st_data,
   output dlx_isa_pkg::word_t                       pc
);

   dlx_pipe_pkg::if_id_t  if_d;
   dlx_pipe_pkg::if_id_t  if_q;
   dlx_pipe_pkg::id_ex_t  id_d;
   dlx_pipe_pkg::id_ex_t  id_q;
   dlx_pipe_pkg::ex_mem_t ex_d;
   dlx_pipe_pkg::ex_mem_t ex_q;
   dlx_pipe_pkg::mem_wb_t mem_d;
   dlx_pipe_pkg::mem_wb_t mem_q;
   logic                  stall;
   logic                  redirect;
   dlx_isa_pkg::word_t    target;

   dlx_fwd_if fwd_ex ();
   dlx_fwd_if fwd_mem ();
   dlx_fwd_if fwd_wb ();

   dlx_fetch fetch_inst (
      .clk       (clk),
      .rst       (rst),
      .stall     (stall),
      .redirect  (redirect),
      .target    (target),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .if_out    (if_d),
      .pc        (pc)
   );

   // redirect kills the instruction fetched behind the branch
   dlx_pipe_reg #(.T(dlx_pipe_pkg::if_id_t)) if_id_reg (
      .clk    (clk),
      .rst    (rst),
      .stall  (stall),
      .flush  (redirect),
      .bubble ('0),
      .d      (if_d),
      .q      (if_q)
   );

   dlx_decode decode_inst (
      .clk      (clk),
      .rst      (rst),
      .id_in    (if_q),
      .fwd_ex   (fwd_ex),
      .fwd_mem  (fwd_mem),
      .wb_en    (wb_en),
      .wb_reg   (wb_reg),
      .wb_data  (wb_data),
      .id_out   (id_d),
      .stall    (stall),
      .redirect (redirect),
      .target   (target)
   );

   // a stalled decode sends a bubble into execute
   dlx_pipe_reg #(.T(dlx_pipe_pkg::id_ex_t)) id_ex_reg (
      .clk    (clk),
      .rst    (rst),
      .stall  (1'b0),
      .flush  (stall),
      .bubble ('0),
      .d      (id_d),
      .q      (id_q)
   );

   dlx_execute execute_inst (
      .ex_in   (id_q),
      .fwd_mem (fwd_mem),
      .fwd_wb  (fwd_wb),
      .fwd_ex  (fwd_ex),
      .ex_out  (ex_d)
   );

   dlx_pipe_reg #(.T(dlx_pipe_pkg::ex_mem_t)) ex_mem_reg (
      .clk    (clk),
      .rst    (rst),
      .stall  (1'b0),
      .flush  (1'b0),
      .bubble ('0),
      .d      (ex_d),
      .q      (ex_q)
   );

   dlx_mem_stage mem_stage_inst (
      .clk     (clk),
      .mem_in  (ex_q),
      .fwd_mem (fwd_mem),
      .mem_out (mem_d),
      .st_en   (st_en),
      .st_addr (st_addr),
      .st_data (st_data)
   );

   dlx_pipe_reg #(.T(dlx_pipe_pkg::mem_wb_t)) mem_wb_reg (
      .clk    (clk),
      .rst    (rst),
      .stall  (1'b0),
      .flush  (1'b0),
      .bubble ('0),
      .d      (mem_d),
      .q      (mem_q)
   );

   // writeback goes to the register file, the top ports and execute
   assign wb_en   = mem_q.valid && mem_q.reg_write;
   assign wb_reg  = mem_q.dst;
   assign wb_data = mem_q.wb_data;

   // data is final by writeback
   assign fwd_wb.reg_write = wb_en;
   assign fwd_wb.dst       = wb_reg;
   assign fwd_wb.data      = wb_data;
   assign fwd_wb.is_load   = 1'b0;

endmodule

`default_nettype wire

/* testbench/dlx_cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dlx_cfg.svh"

module dlx_cpu_tb;

   localparam logic [1:0] kind_none = 2'd0;
   localparam logic [1:0] kind_wb   = 2'd1;
   localparam logic [1:0] kind_st   = 2'd2;
   localparam int wait_limit   = 200;
   localparam int quiet_cycles = 30;

   // one program word with what it should do
   // a is the register or store address, b the value or store data
   typedef struct packed {
      dlx_isa_pkg::word_t instr;
      logic [1:0]         kind;
      dlx_isa_pkg::word_t a;
      dlx_isa_pkg::word_t b;
   } step_t;

   logic                                clk;
   logic                                rst;
   logic                                load_en;
   logic [$clog2(`DLX_IMEM_DEPTH)-1:0]  load_addr;
   dlx_isa_pkg::word_t                  load_data;
   logic                                wb_en;
   dlx_isa_pkg::reg_idx_t               wb_reg;
   dlx_isa_pkg::word_t                  wb_data;
   logic                                st_en;
   dlx_isa_pkg::word_t                  st_addr;
   dlx_isa_pkg::word_t                  st_data;
   dlx_isa_pkg::word_t                  pc;

   step_t                 prog [$];
   dlx_isa_pkg::reg_idx_t wb_exp_reg [$];
   dlx_isa_pkg::word_t    wb_exp_data [$];
   dlx_isa_pkg::word_t    st_exp_addr [$];
   dlx_isa_pkg::word_t    st_exp_data [$];
   int                    mismatches;
   int                    timeouts;
   int                    unexpected;

   dlx_cpu dlx_cpu_inst (
      .clk       (clk),
      .rst       (rst),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .wb_en     (wb_en),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .st_en     (st_en),
      .st_addr   (st_addr),
      .st_data   (st_data),
      .pc        (pc)
   );

   always #2 clk = ~clk;

   // r-type layout: opcode 0, rs1, rs2, rd, shamt 0, funct
   function automatic dlx_isa_pkg::word_t r_word(dlx_isa_pkg::funct_t fn,
         dlx_isa_pkg::reg_idx_t rd, dlx_isa_pkg::reg_idx_t rs1, dlx_isa_pkg::reg_idx_t rs2);
      return {6'h00, rs1, rs2, rd, 5'd0, fn};
   endfunction

   // i-type layout: opcode, rs1, rt in the rs2 field, imm16
   function automatic dlx_isa_pkg::word_t i_word(dlx_isa_pkg::opcode_t op,
         dlx_isa_pkg::reg_idx_t rt, dlx_isa_pkg::reg_idx_t rs1, logic [15:0] imm);
      return {op, rs1, rt, imm};
   endfunction

   function automatic dlx_isa_pkg::word_t j_word(logic [25:0] offset);
      return {dlx_isa_pkg::op_j, offset};
   endfunction

   task automatic add_step(dlx_isa_pkg::word_t instr, logic [1:0] kind,
                           dlx_isa_pkg::word_t a, dlx_isa_pkg::word_t b);
      prog.push_back('{instr, kind, a, b});
   endtask

   task automatic check_wb(dlx_isa_pkg::reg_idx_t got_reg, dlx_isa_pkg::word_t got_data,
                           dlx_isa_pkg::reg_idx_t exp_reg, dlx_isa_pkg::word_t exp_data);
      if (got_reg !== exp_reg || got_data !== exp_data) begin
         mismatches++;
         $display("error at %0t: writeback r%0d = %h, expected r%0d = %h",
                  $time, got_reg, got_data, exp_reg, exp_data);
      end
   endtask

   task automatic check_st(dlx_isa_pkg::word_t got_addr, dlx_isa_pkg::word_t got_data,
                           dlx_isa_pkg::word_t exp_addr, dlx_isa_pkg::word_t exp_data);
      if (got_addr !== exp_addr || got_data !== exp_data) begin
         mismatches++;
         $display("error at %0t: store [%h] = %h, expected [%h] = %h",
                  $time, got_addr, got_data, exp_addr, exp_data);
      end
   endtask

   task automatic check_pc(dlx_isa_pkg::word_t got_pc, dlx_isa_pkg::word_t exp_pc);
      if (got_pc !== exp_pc) begin
         mismatches++;
         $display("error at %0t: pc %h, expected %h", $time, got_pc, exp_pc);
      end
   endtask

   // outputs are sampled on the falling edge, away from the register updates
   task automatic watch_writebacks();
      int waited;
      while (wb_exp_reg.size() != 0) begin
         waited = 0;
         do begin
            @(negedge clk);
            waited++;
         end while (!wb_en && waited < wait_limit);
         if (!wb_en) begin
            timeouts++;
            $display("the writeback to r%0d never arrived", wb_exp_reg[0]);
            return;
         end
         check_wb(wb_reg, wb_data, wb_exp_reg.pop_front(), wb_exp_data.pop_front());
      end
   endtask

   task automatic watch_stores();
      int waited;
      while (st_exp_addr.size() != 0) begin
         waited = 0;
         do begin
            @(negedge clk);
            waited++;
         end while (!st_en && waited < wait_limit);
         if (!st_en) begin
            timeouts++;
            $display("the store to address %h never arrived", st_exp_addr[0]);
            return;
         end
         check_st(st_addr, st_data, st_exp_addr.pop_front(), st_exp_data.pop_front());
      end
   endtask

   // the program spins on its last jump, so nothing more may come out
   task automatic watch_quiet();
      int                 n;
      dlx_isa_pkg::word_t spin_pc;
      spin_pc = 4 * (prog.size() - 1);
      for (n = 0; n < quiet_cycles; n++) begin
         @(negedge clk);
         if (wb_en) begin
            unexpected++;
            $display("an extra writeback to r%0d showed up after the program", wb_reg);
         end
         if (st_en) begin
            unexpected++;
            $display("an extra store to address %h showed up after the program", st_addr);
         end
         // the final jump and the killed word behind it are fetched in turn
         // the first quiet cycle fetches the jump itself
         check_pc(pc, (n % 2 == 0) ? spin_pc : spin_pc + 'd4);
      end
   endtask

   task automatic build_program();
      // operands, with a negative sign-extended immediate
      add_step(i_word(dlx_isa_pkg::op_addi, 1, 0, 16'd5), kind_wb, 1, 32'h0000_0005);
      add_step(i_word(dlx_isa_pkg::op_addi, 2, 0, 16'hfffd), kind_wb, 2, 32'hffff_fffd);
      // r-type set, r2 straight from the previous instruction
      add_step(r_word(dlx_isa_pkg::fn_add, 3, 1, 2), kind_wb, 3, 32'h0000_0002);
      add_step(r_word(dlx_isa_pkg::fn_sub, 4, 2, 1), kind_wb, 4, 32'hffff_fff8);
      add_step(r_word(dlx_isa_pkg::fn_and, 5, 1, 2), kind_wb, 5, 32'h0000_0005);
      add_step(r_word(dlx_isa_pkg::fn_or, 6, 1, 2), kind_wb, 6, 32'hffff_fffd);
      add_step(r_word(dlx_isa_pkg::fn_xor, 7, 1, 2), kind_wb, 7, 32'hffff_fff8);
      add_step(r_word(dlx_isa_pkg::fn_sll, 8, 1, 1), kind_wb, 8, 32'h0000_00a0);
      add_step(r_word(dlx_isa_pkg::fn_srl, 9, 2, 1), kind_wb, 9, 32'h07ff_ffff);
      // signed compare, -3 < 5
      add_step(r_word(dlx_isa_pkg::fn_slt, 10, 2, 1), kind_wb, 10, 32'h0000_0001);
      add_step(r_word(dlx_isa_pkg::fn_slt, 11, 1, 2), kind_wb, 11, 32'h0000_0000);
      // immediates, slti sees 5 against -2 and the logic ops zero-extend
      add_step(i_word(dlx_isa_pkg::op_slti, 12, 1, 16'hfffe), kind_wb, 12, 32'h0000_0000);
      add_step(i_word(dlx_isa_pkg::op_andi, 13, 2, 16'hfff0), kind_wb, 13, 32'h0000_fff0);
      add_step(i_word(dlx_isa_pkg::op_ori, 14, 0, 16'h8001), kind_wb, 14, 32'h0000_8001);
      add_step(i_word(dlx_isa_pkg::op_xori, 15, 2, 16'hffff), kind_wb, 15, 32'hffff_0002);
      // dependency chain at distances one, two and three
      add_step(i_word(dlx_isa_pkg::op_addi, 16, 0, 16'h0040), kind_wb, 16, 32'h0000_0040);
      add_step(i_word(dlx_isa_pkg::op_addi, 17, 16, 16'h0001), kind_wb, 17, 32'h0000_0041);
      add_step(r_word(dlx_isa_pkg::fn_add, 18, 16, 17), kind_wb, 18, 32'h0000_0081);
      add_step(r_word(dlx_isa_pkg::fn_add, 19, 16, 18), kind_wb, 19, 32'h0000_00c1);
      // sw base and data both come straight from the previous add
      // reload with the same negative offset and use the load at once
      add_step(i_word(dlx_isa_pkg::op_sw, 19, 19, 16'hffff), kind_st, 32'hc0, 32'h0000_00c1);
      add_step(i_word(dlx_isa_pkg::op_lw, 20, 19, 16'hffff), kind_wb, 20, 32'h0000_00c1);
      add_step(r_word(dlx_isa_pkg::fn_add, 21, 20, 1), kind_wb, 21, 32'h0000_00c6);
      add_step(i_word(dlx_isa_pkg::op_sw, 21, 16, 16'h0000), kind_st, 32'h40, 32'h0000_00c6);
      // taken beqz kills the next word
      add_step(i_word(dlx_isa_pkg::op_beqz, 0, 0, 16'h0004), kind_none, 0, 0);
      add_step(i_word(dlx_isa_pkg::op_addi, 22, 0, 16'd99), kind_none, 0, 0);
      add_step(i_word(dlx_isa_pkg::op_addi, 23, 0, 16'd7), kind_wb, 23, 32'h0000_0007);
      // bnez on r23 from the ALU op just ahead of it
      add_step(i_word(dlx_isa_pkg::op_bnez, 0, 23, 16'h0004), kind_none, 0, 0);
      add_step(i_word(dlx_isa_pkg::op_addi, 22, 0, 16'd98), kind_none, 0, 0);
      // neither branch is taken
      add_step(i_word(dlx_isa_pkg::op_beqz, 0, 23, 16'h0004), kind_none, 0, 0);
      add_step(i_word(dlx_isa_pkg::op_addi, 24, 0, 16'd11), kind_wb, 24, 32'h0000_000b);
      add_step(i_word(dlx_isa_pkg::op_bnez, 0, 0, 16'h0004), kind_none, 0, 0);
      add_step(i_word(dlx_isa_pkg::op_addi, 25, 24, 16'd1), kind_wb, 25, 32'h0000_000c);
      add_step(j_word(26'h000_0004), kind_none, 0, 0);
      add_step(i_word(dlx_isa_pkg::op_addi, 22, 0, 16'd97), kind_none, 0, 0);
      // r0 as a target is silent and still reads zero afterwards
      add_step(i_word(dlx_isa_pkg::op_addi, 0, 1, 16'd9), kind_none, 0, 0);
      add_step(r_word(dlx_isa_pkg::fn_add, 26, 0, 1), kind_wb, 26, 32'h0000_0005);
      add_step(j_word(26'h3ff_fffc), kind_none, 0, 0);
   endtask

   initial begin
      int i;
      clk        = 1'b0;
      rst        = 1'b1;
      load_en    = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      mismatches = 0;
      timeouts   = 0;
      unexpected = 0;

      build_program();
      for (i = 0; i < prog.size(); i++) begin
         if (prog[i].kind == kind_wb) begin
            wb_exp_reg.push_back(dlx_isa_pkg::reg_idx_t'(prog[i].a));
            wb_exp_data.push_back(prog[i].b);
         end else if (prog[i].kind == kind_st) begin
            st_exp_addr.push_back(prog[i].a);
            st_exp_data.push_back(prog[i].b);
         end
      end

      // load the whole program while rst stays high
      for (i = 0; i < prog.size(); i++) begin
         @(posedge clk);
         load_en   <= 1'b1;
         load_addr <= i;
         load_data <= prog[i].instr;
      end
      @(posedge clk);
      load_en <= 1'b0;
      // pc sits at zero while in reset
      @(negedge clk);
      check_pc(pc, '0);
      @(posedge clk);
      rst <= 1'b0;

      fork
         watch_writebacks();
         watch_stores();
      join
      watch_quiet();

      $display("mismatches %0d, timeouts %0d, unexpected %0d", mismatches, timeouts, unexpected);
      if (mismatches == 0 && timeouts == 0 && unexpected == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dlx_cpu.f */
+incdir+common
common/dlx_isa_pkg.sv
common/dlx_pipe_pkg.sv
common/dlx_fwd_if.sv
source/dlx_pipe_reg.sv
source/dlx_fetch.sv
decode/dlx_regfile.sv
decode/dlx_decode.sv
execute/dlx_alu.sv
execute/dlx_execute.sv
source/dlx_mem_stage.sv
source/dlx_cpu.sv
testbench/dlx_cpu_tb.sv
